/* build.f */
+incdir+tests
common/soc_bus_pkg.sv
common/soc_regs_pkg.sv
rtl/dbg_loader.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/scratch_ram.sv
misc/fsel_sequencer.sv
misc/misc_regs.sv
rtl/soc_top.sv
tests/tb_soc.sv

/* common/soc_bus_pkg.sv */
// system bus types shared by the masters, the arbiter, the decoder and the bus targets
package soc_bus_pkg;

	// address and strobe widths of the system bus
	localparam int BUS_ADDR_W = 32;
	localparam int BUS_STRB_W = 4;

	// master to target, held stable by the master until ready
	// a wstrb of zero means a read
	typedef struct packed {
		logic                  valid;
		logic [BUS_ADDR_W-1:0] addr;
		logic [31:0]           wdata;
		logic [BUS_STRB_W-1:0] wstrb;
	} bus_req_t;

	// target to master, the transfer ends in the cycle ready is high
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// region select from address bits 31:28
	// any nibble not listed here is a bus error
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2,
		REGION_RAM  = 4'h4
	} region_e;

	// read value returned for an unmapped access
	localparam logic [31:0] BUS_ERROR_WORD = 32'hDEAD_BEEF;

endpackage

/* common/soc_regs_pkg.sv */
// register map of the misc block and the debug-port word format
package soc_regs_pkg;

	// word index within the misc region, address bits 5:2
	typedef enum logic [3:0] {
		MISC_REG_LED       = 4'd0,
		MISC_REG_BTN       = 4'd1,
		MISC_REG_SOC_VER   = 4'd2,
		MISC_REG_FLASH_SEL = 4'd11
	} misc_reg_e;

	// one debug-port word, sel high means the data is an address
	typedef struct packed {
		logic        sel;
		logic [31:0] data;
	} dbg_word_t;

	localparam logic [31:0] SOC_VERSION = 32'h0000_8000;

	// low 24 bits of a FLASH_SEL write that arm the PROGRAMN reload
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// start value of the flash-select countdown
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;

	localparam int LED_W = 16;
	localparam int BTN_W = 8;

endpackage

/* misc/fsel_sequencer.sv */
// flash-select countdown, clocks fsel_d into the select flop and then pulls PROGRAMN
`timescale 1ns/10ps

module fsel_sequencer (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe,
	input  logic reload_armed,
	output logic fsel_c,
	output logic programn
);
	import soc_regs_pkg::*;

	logic [$bits(FSEL_DELAY_START)-1:0] count;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			count    <= '0;
			programn <= 1'b1;
		end else begin
			if (fsel_strobe) begin
				count <= FSEL_DELAY_START;
			end else if (count != '0) begin
				count <= count - 1'b1;
				// select flop has settled by now, safe to reload
				if (count == 1 && reload_armed) begin
					programn <= 1'b0;
				end
			end
		end
	end

	// clock edge sits three cycles after fsel_d changes, low again well before the reload
	assign fsel_c = (count == 3'd5) || (count == 3'd4) || (count == 3'd3);

endmodule

/* misc/misc_regs.sv */
// misc register block with LEDs, buttons, version and the flash-select/reload control
`timescale 1ns/10ps

module misc_regs (
	input  logic                          clk48m,
	input  logic                          rst,
	input  logic                          misc_sel,
	input  soc_bus_pkg::bus_req_t         sys_req,
	output soc_bus_pkg::bus_rsp_t         misc_rsp,
	input  logic [soc_regs_pkg::BTN_W-1:0] btn,
	output logic [soc_regs_pkg::LED_W-1:0] led,
	output logic                          fsel_d,
	output logic                          programn,
	output logic                          fsel_c
);
	import soc_regs_pkg::*;

	misc_reg_e reg_idx;
	logic      wr_en;
	logic      fsel_strobe;
	logic      reload_armed;

	assign reg_idx = misc_reg_e'(sys_req.addr[5:2]);
	// only byte lane 0 counts as a register write
	assign wr_en   = misc_sel && sys_req.wstrb[0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led          <= '0;
			fsel_d       <= 1'b0;
			fsel_strobe  <= 1'b0;
			reload_armed <= 1'b0;
		end else begin
			fsel_strobe <= 1'b0;
			if (wr_en) begin
				case (reg_idx)
					MISC_REG_LED: led <= sys_req.wdata[LED_W-1:0];
					MISC_REG_FLASH_SEL: begin
						fsel_d      <= sys_req.wdata[0];
						fsel_strobe <= 1'b1;
						// stays armed until reset, the reload ends this config anyway
						if (sys_req.wdata[23:0] == RELOAD_KEY) begin
							reload_armed <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// every access completes in its select cycle
	assign misc_rsp.ready = misc_sel;

	always_comb begin
		case (reg_idx)
			MISC_REG_LED:       misc_rsp.rdata = {{(32-LED_W){1'b0}}, led};
			MISC_REG_BTN:       misc_rsp.rdata = {{(32-BTN_W){1'b0}}, ~btn};
			MISC_REG_SOC_VER:   misc_rsp.rdata = SOC_VERSION;
			MISC_REG_FLASH_SEL: misc_rsp.rdata = {31'h0, fsel_d};
			default:            misc_rsp.rdata = '0;
		endcase
	end

	fsel_sequencer u_fsel_sequencer (
		.clk48m       (clk48m),
		.rst          (rst),
		.fsel_strobe  (fsel_strobe),
		.reload_armed (reload_armed),
		.fsel_c       (fsel_c),
		.programn     (programn)
	);

endmodule

/* rtl/bus_arbiter.sv */
// two-master arbiter for the host port and the debug loader, host first
`timescale 1ns/10ps

module bus_arbiter (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_bus_pkg::bus_req_t host_req,
	output soc_bus_pkg::bus_rsp_t host_rsp,
	input  soc_bus_pkg::bus_req_t dbg_req,
	output soc_bus_pkg::bus_rsp_t dbg_rsp,
	output soc_bus_pkg::bus_req_t sys_req,
	input  soc_bus_pkg::bus_rsp_t sys_rsp
);

	typedef enum logic [1:0] {
		GRANT_IDLE,
		GRANT_HOST,
		GRANT_DBG
	} grant_e;

	grant_e grant;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			grant <= GRANT_IDLE;
		end else begin
			case (grant)
				GRANT_IDLE: begin
					if (host_req.valid) begin
						grant <= GRANT_HOST;
					end else if (dbg_req.valid) begin
						grant <= GRANT_DBG;
					end
				end
				// hold until the target answers, then one idle cycle
				GRANT_HOST, GRANT_DBG: begin
					if (sys_rsp.ready) begin
						grant <= GRANT_IDLE;
					end
				end
				default: grant <= GRANT_IDLE;
			endcase
		end
	end

	always_comb begin
		case (grant)
			GRANT_HOST: sys_req = host_req;
			GRANT_DBG:  sys_req = dbg_req;
			default:    sys_req = '0;
		endcase
	end

	// rdata goes to both, only the granted master sees ready
	assign host_rsp.rdata = sys_rsp.rdata;
	assign host_rsp.ready = (grant == GRANT_HOST) && sys_rsp.ready;
	assign dbg_rsp.rdata  = sys_rsp.rdata;
	assign dbg_rsp.ready  = (grant == GRANT_DBG) && sys_rsp.ready;

	// a granted master must not change its request before ready
	assert property (@(posedge clk48m) disable iff (rst)
		(grant != GRANT_IDLE && !sys_rsp.ready) |=> $stable(sys_req))
		else $error("granted master changed its request before ready");

endmodule

/* rtl/bus_decoder.sv */
// address decoder, picks the bus target, muxes the responses and flags bus errors
`timescale 1ns/10ps

module bus_decoder #(
	parameter int RAM_WORDS = 256
) (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_bus_pkg::bus_req_t sys_req,
	output soc_bus_pkg::bus_rsp_t sys_rsp,
	output logic                  misc_sel,
	output logic                  ram_sel,
	input  soc_bus_pkg::bus_rsp_t misc_rsp,
	input  soc_bus_pkg::bus_rsp_t ram_rsp,
	output logic                  bus_error_irq
);
	import soc_bus_pkg::*;

	region_e  region;
	bus_rsp_t error_rsp;
	logic     bus_error;

	assign region = region_e'(sys_req.addr[31:28]);

	always_comb begin
		misc_sel  = 1'b0;
		ram_sel   = 1'b0;
		bus_error = 1'b0;
		case (region)
			REGION_MISC: misc_sel = sys_req.valid;
			REGION_RAM: begin
				// words past the end of the RAM are unmapped
				if (sys_req.addr[27:2] < 26'(RAM_WORDS)) begin
					ram_sel = sys_req.valid;
				end else begin
					bus_error = sys_req.valid;
				end
			end
			default: bus_error = sys_req.valid;
		endcase
	end

	// errors answer in the same cycle
	assign error_rsp.ready = bus_error;
	assign error_rsp.rdata = BUS_ERROR_WORD;

	always_comb begin
		if (misc_sel) begin
			sys_rsp = misc_rsp;
		end else if (ram_sel) begin
			sys_rsp = ram_rsp;
		end else if (bus_error) begin
			sys_rsp = error_rsp;
		end else begin
			sys_rsp = '0;
		end
	end

	// one pulse per error access, the master leaves on the error ready
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_error_irq <= 1'b0;
		end else begin
			bus_error_irq <= bus_error;
		end
	end

	// the RAM answers a cycle late, the request must still be there
	assert property (@(posedge clk48m) disable iff (rst) ram_rsp.ready |-> ram_sel)
		else $error("RAM ready while not selected");

endmodule

/* rtl/dbg_loader.sv */
// debug-port loader, queues debug words and replays them as full-word bus writes
`timescale 1ns/10ps

module dbg_loader #(
	parameter int DBG_FIFO_DEPTH = 32
) (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   dbgreg_strobe,
	input  logic                   dbgreg_sel,
	input  logic [31:0]            dbgreg_in,
	output soc_bus_pkg::bus_req_t  dbg_req,
	input  soc_bus_pkg::bus_rsp_t  dbg_rsp
);
	import soc_bus_pkg::*;
	import soc_regs_pkg::*;

	localparam int PTR_W = $clog2(DBG_FIFO_DEPTH);

	dbg_word_t             fifo_mem [DBG_FIFO_DEPTH];
	dbg_word_t             head;
	logic [PTR_W:0]        wr_ptr;
	logic [PTR_W:0]        rd_ptr;
	logic                  fifo_empty;
	logic                  fifo_full;
	logic                  store_en;
	logic                  pop_en;
	logic [BUS_ADDR_W-1:0] addr_ptr;
	logic [31:0]           wr_data;
	logic                  req_valid;

	// extra pointer bit tells full from empty
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	assign store_en = dbgreg_strobe && !fifo_full;
	// an incoming strobe wins over draining the FIFO
	assign pop_en   = !dbgreg_strobe && !req_valid && !fifo_empty;
	assign head     = fifo_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk48m) begin
		if (store_en) begin
			fifo_mem[wr_ptr[PTR_W-1:0]] <= '{sel: dbgreg_sel, data: dbgreg_in};
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			addr_ptr  <= '0;
			req_valid <= 1'b0;
		end else begin
			if (store_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// write done, step to the next word
			if (req_valid && dbg_rsp.ready) begin
				req_valid <= 1'b0;
				addr_ptr  <= addr_ptr + 32'd4;
			end
			if (pop_en) begin
				if (head.sel) begin
					addr_ptr <= head.data;
				end else begin
					req_valid <= 1'b1;
				end
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// write data of the pending bus request, taken from the popped data word
	always_ff @(posedge clk48m) begin
		if (pop_en && !head.sel) begin
			wr_data <= head.data;
		end
	end

	assign dbg_req.valid = req_valid;
	assign dbg_req.addr  = addr_ptr;
	assign dbg_req.wdata = wr_data;
	assign dbg_req.wstrb = {BUS_STRB_W{1'b1}};

	// the debug port has no flow control, so it must never outrun the bus
	assert property (@(posedge clk48m) disable iff (rst) dbgreg_strobe |-> !fifo_full)
		else $error("debug FIFO overflow, word dropped");

endmodule

/* rtl/scratch_ram.sv */
// word RAM in place of the cached PSRAM, byte writes, registered one-cycle response
`timescale 1ns/10ps

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic                  clk48m,
	input  logic                  rst,
	input  logic                  ram_sel,
	input  soc_bus_pkg::bus_req_t sys_req,
	output soc_bus_pkg::bus_rsp_t ram_rsp
);
	import soc_bus_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem [RAM_WORDS];
	logic [AW-1:0] word_idx;
	logic [31:0]   rdata_q;
	logic          ready_q;
	logic          access;

	assign word_idx = sys_req.addr[AW+1:2];
	// first cycle of a selection only, the answer cycle does nothing
	assign access   = ram_sel && !ready_q;

	always_ff @(posedge clk48m) begin
		for (int b = 0; b < BUS_STRB_W; b++) begin
			if (access && sys_req.wstrb[b]) begin
				mem[word_idx][8*b +: 8] <= sys_req.wdata[8*b +: 8];
			end
		end
		if (access) begin
			rdata_q <= mem[word_idx];
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	assign ram_rsp.ready = ready_q;
	assign ram_rsp.rdata = rdata_q;

endmodule

/* rtl/soc_top.sv */
// system bus core of the SoC, host port and debug loader sharing misc registers and RAM
`timescale 1ns/10ps

module soc_top #(
	parameter int RAM_WORDS      = 256,
	parameter int DBG_FIFO_DEPTH = 32
) (
	input  logic                           clk48m,
	input  logic                           rst,
	input  soc_bus_pkg::bus_req_t          host_req,
	output soc_bus_pkg::bus_rsp_t          host_rsp,
	input  logic                           dbgreg_strobe,
	input  logic                           dbgreg_sel,
	input  logic [31:0]                    dbgreg_in,
	input  logic [soc_regs_pkg::BTN_W-1:0] btn,
	output logic [soc_regs_pkg::LED_W-1:0] led,
	output logic                           fsel_d,
	output logic                           fsel_c,
	output logic                           programn,
	output logic                           bus_error_irq
);
	import soc_bus_pkg::*;

	bus_req_t dbg_req;
	bus_rsp_t dbg_rsp;
	bus_req_t sys_req;
	bus_rsp_t sys_rsp;
	bus_rsp_t misc_rsp;
	bus_rsp_t ram_rsp;
	logic     misc_sel;
	logic     ram_sel;

	dbg_loader #(
		.DBG_FIFO_DEPTH (DBG_FIFO_DEPTH)
	) u_dbg_loader (
		.clk48m        (clk48m),
		.rst           (rst),
		.dbgreg_strobe (dbgreg_strobe),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_in     (dbgreg_in),
		.dbg_req       (dbg_req),
		.dbg_rsp       (dbg_rsp)
	);

	bus_arbiter u_bus_arbiter (
		.clk48m   (clk48m),
		.rst      (rst),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.dbg_req  (dbg_req),
		.dbg_rsp  (dbg_rsp),
		.sys_req  (sys_req),
		.sys_rsp  (sys_rsp)
	);

	bus_decoder #(
		.RAM_WORDS (RAM_WORDS)
	) u_bus_decoder (
		.clk48m        (clk48m),
		.rst           (rst),
		.sys_req       (sys_req),
		.sys_rsp       (sys_rsp),
		.misc_sel      (misc_sel),
		.ram_sel       (ram_sel),
		.misc_rsp      (misc_rsp),
		.ram_rsp       (ram_rsp),
		.bus_error_irq (bus_error_irq)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_scratch_ram (
		.clk48m  (clk48m),
		.rst     (rst),
		.ram_sel (ram_sel),
		.sys_req (sys_req),
		.ram_rsp (ram_rsp)
	);

	misc_regs u_misc_regs (
		.clk48m   (clk48m),
		.rst      (rst),
		.misc_sel (misc_sel),
		.sys_req  (sys_req),
		.misc_rsp (misc_rsp),
		.btn      (btn),
		.led      (led),
		.fsel_d   (fsel_d),
		.programn (programn),
		.fsel_c   (fsel_c)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SoC bus core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f build.f \
	--Mdir obj_dir -o tb_soc_sim > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_soc_sim > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tests/tb_soc_tasks.svh */
// bus, debug-port, RAM model and check tasks of the SoC testbench, included inside tb_soc
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

// the reason has been printed already, end the run here
task automatic abort_run();
	$display("*** FAILED ***");
	$fatal(1, "simulation stopped on the first error");
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		abort_run();
	end
endtask

// RAM wraps on its word count, index from the word address
function automatic int ram_index(input logic [31:0] addr);
	return int'(addr[31:2]) % RAM_WORDS;
endfunction

// byte lanes follow the write strobe
task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
	int idx;
	idx = ram_index(addr);
	for (int b = 0; b < 4; b++) begin
		if (strb[b]) begin
			ram_model[idx][8*b +: 8] = data[8*b +: 8];
		end
	end
endtask

// starts on a falling edge, returns on the falling edge after the transfer
task automatic host_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
	int waited;
	host_req.valid = 1'b1;
	host_req.addr  = addr;
	host_req.wdata = wdata;
	host_req.wstrb = wstrb;
	waited = 0;
	@(negedge clk48m);
	while (host_rsp.ready !== 1'b1) begin
		waited++;
		if (waited > 50) begin
			$display("host access to %h got no ready within 50 cycles", addr);
			abort_run();
		end
		@(negedge clk48m);
	end
	rdata = host_rsp.rdata;
	// the transfer completes on the rising edge in between
	@(negedge clk48m);
	host_req = '0;
endtask

task automatic send_dbg_word(input logic sel, input logic [31:0] data);
	dbgreg_strobe = 1'b1;
	dbgreg_sel    = sel;
	dbgreg_in     = data;
	@(negedge clk48m);
	dbgreg_strobe = 1'b0;
	dbgreg_sel    = 1'b0;
	dbgreg_in     = '0;
	// debug port is slow, a gap between words
	repeat (2) @(negedge clk48m);
endtask

// done once the FIFO is empty and the last write has been acknowledged
task automatic wait_dbg_idle();
	int waited;
	waited = 0;
	while (!(u_soc_top.u_dbg_loader.fifo_empty && !u_soc_top.u_dbg_loader.req_valid)) begin
		waited++;
		if (waited > 100) begin
			$display("debug loader did not finish its writes within 100 cycles");
			abort_run();
		end
		@(negedge clk48m);
	end
endtask

`endif

/* tests/tb_soc.sv */
// testbench for soc_top, applies a table of host, debug-port and register steps
`timescale 1ns/10ps

module tb_soc;
	import soc_bus_pkg::*;

	localparam int RAM_WORDS      = 256;
	localparam int DBG_FIFO_DEPTH = 32;
	localparam logic [31:0] MISC_BASE = 32'h2000_0000;
	localparam logic [31:0] RAM_BASE  = 32'h4000_0000;

	typedef enum logic [3:0] {
		OP_WRITE,
		OP_READ,
		OP_DBG_ADDR,
		OP_DBG_DATA,
		OP_DBG_WAIT,
		OP_LED_PORT,
		OP_ERR_READ,
		OP_FSEL,
		OP_RELOAD
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] expected;
	} step_t;

	logic        clk48m;
	logic        rst;
	bus_req_t    host_req;
	bus_rsp_t    host_rsp;
	logic        dbgreg_strobe;
	logic        dbgreg_sel;
	logic [31:0] dbgreg_in;
	logic [7:0]  btn;
	logic [15:0] led;
	logic        fsel_d;
	logic        fsel_c;
	logic        programn;
	logic        bus_error_irq;

	step_t       steps[$];
	logic [31:0] ram_model [RAM_WORDS];
	logic [31:0] dbg_ptr;
	logic [7:0]  btn_value;
	int          seed;
	bit          table_ready;

	soc_top #(
		.RAM_WORDS      (RAM_WORDS),
		.DBG_FIFO_DEPTH (DBG_FIFO_DEPTH)
	) u_soc_top (
		.clk48m        (clk48m),
		.rst           (rst),
		.host_req      (host_req),
		.host_rsp      (host_rsp),
		.dbgreg_strobe (dbgreg_strobe),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_in     (dbgreg_in),
		.btn           (btn),
		.led           (led),
		.fsel_d        (fsel_d),
		.fsel_c        (fsel_c),
		.programn      (programn),
		.bus_error_irq (bus_error_irq)
	);

	`include "tb_soc_tasks.svh"

	function automatic void add_step(input op_e op, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] expected);
		steps.push_back('{op: op, addr: addr, data: data, strb: strb, expected: expected});
	endfunction

	task automatic build_table();
		logic [31:0] led_val;
		// full words first so that partial writes land on known bytes
		add_step(OP_WRITE, RAM_BASE, $random(seed), 4'b1111, '0);
		add_step(OP_WRITE, RAM_BASE + 32'h4, $random(seed), 4'b1111, '0);
		add_step(OP_WRITE, RAM_BASE + 32'h8, $random(seed), 4'b1111, '0);
		add_step(OP_WRITE, RAM_BASE + 32'h3FC, $random(seed), 4'b1111, '0);
		add_step(OP_WRITE, RAM_BASE + 32'h4, $random(seed), 4'b0001, '0);
		add_step(OP_WRITE, RAM_BASE + 32'h8, $random(seed), 4'b1100, '0);
		add_step(OP_WRITE, RAM_BASE, $random(seed), 4'b0110, '0);
		add_step(OP_READ, RAM_BASE, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h4, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h8, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h3FC, '0, 4'b0000, '0);
		// debug port loads three words from one address word
		add_step(OP_DBG_ADDR, '0, RAM_BASE + 32'h100, 4'b0000, '0);
		add_step(OP_DBG_DATA, '0, $random(seed), 4'b0000, '0);
		add_step(OP_DBG_DATA, '0, $random(seed), 4'b0000, '0);
		add_step(OP_DBG_DATA, '0, $random(seed), 4'b0000, '0);
		add_step(OP_DBG_WAIT, '0, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h100, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h104, '0, 4'b0000, '0);
		add_step(OP_READ, RAM_BASE + 32'h108, '0, 4'b0000, '0);
		led_val = $random(seed);
		add_step(OP_WRITE, MISC_BASE, led_val, 4'b1111, '0);
		add_step(OP_LED_PORT, '0, '0, 4'b0000, {16'h0, led_val[15:0]});
		add_step(OP_READ, MISC_BASE, '0, 4'b0000, {16'h0, led_val[15:0]});
		add_step(OP_READ, MISC_BASE + 32'h4, '0, 4'b0000, {24'h0, ~btn_value});
		add_step(OP_READ, MISC_BASE + 32'h8, '0, 4'b0000, 32'h0000_8000);
		add_step(OP_READ, MISC_BASE + 32'h14, '0, 4'b0000, 32'h0);
		add_step(OP_ERR_READ, 32'h0000_0010, '0, 4'b0000, 32'hDEAD_BEEF);
		add_step(OP_ERR_READ, RAM_BASE + RAM_WORDS * 4, '0, 4'b0000, 32'hDEAD_BEEF);
		add_step(OP_FSEL, MISC_BASE + 32'h2C, 32'h1, 4'b1111, 32'h1);
		add_step(OP_READ, MISC_BASE + 32'h2C, '0, 4'b0000, 32'h1);
		// key in the low 24 bits, bit 0 keeps fsel_d set
		add_step(OP_RELOAD, MISC_BASE + 32'h2C, 32'h00D0_F1A5, 4'b1111, '0);
	endtask

	task automatic apply_step(input step_t s);
		logic [31:0] rd;
		int          highs;
		int          runs;
		int          waited;
		logic        prev;
		case (s.op)
			OP_WRITE: begin
				host_access(s.addr, s.data, s.strb, rd);
				if (s.addr[31:28] == 4'h4) begin
					model_write(s.addr, s.data, s.strb);
				end
			end
			OP_READ: begin
				host_access(s.addr, '0, 4'b0000, rd);
				if (s.addr[31:28] == 4'h4) begin
					check_value(rd, ram_model[ram_index(s.addr)], $sformatf("RAM read %h", s.addr));
				end else begin
					check_value(rd, s.expected, $sformatf("register read %h", s.addr));
				end
			end
			OP_DBG_ADDR: begin
				send_dbg_word(1'b1, s.data);
				dbg_ptr = s.data;
			end
			OP_DBG_DATA: begin
				send_dbg_word(1'b0, s.data);
				model_write(dbg_ptr, s.data, 4'b1111);
				dbg_ptr = dbg_ptr + 32'd4;
			end
			OP_DBG_WAIT: wait_dbg_idle();
			OP_LED_PORT: check_value(led, s.expected, "led port");
			OP_ERR_READ: begin
				check_value(bus_error_irq, 1'b0, "irq before error access");
				host_access(s.addr, '0, 4'b0000, rd);
				check_value(rd, s.expected, $sformatf("error read %h", s.addr));
				check_value(bus_error_irq, 1'b1, "irq after error access");
				@(negedge clk48m);
				check_value(bus_error_irq, 1'b0, "irq one cycle later");
			end
			OP_FSEL: begin
				host_access(s.addr, s.data, s.strb, rd);
				check_value(fsel_d, s.expected, "fsel_d after write");
				highs = 0;
				runs  = 0;
				prev  = 1'b0;
				repeat (12) begin
					@(negedge clk48m);
					if (fsel_c && !prev) begin
						runs++;
					end
					if (fsel_c) begin
						highs++;
					end
					prev = fsel_c;
					check_value(programn, 1'b1, "programn during flash select");
				end
				check_value(highs, 3, "fsel_c high cycles");
				check_value(runs, 1, "fsel_c pulses");
			end
			OP_RELOAD: begin
				host_access(s.addr, s.data, s.strb, rd);
				waited = 0;
				while (programn && waited < 10) begin
					@(negedge clk48m);
					waited++;
				end
				check_value(programn, 1'b0, "programn within ten cycles of reload");
				repeat (5) begin
					@(negedge clk48m);
					check_value(programn, 1'b0, "programn stays low");
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		clk48m = 1'b0;
		forever #10 clk48m = ~clk48m;
	end

	initial begin
		seed          = 32'h4bd8_69d7;
		rst           = 1'b1;
		host_req      = '0;
		dbgreg_strobe = 1'b0;
		dbgreg_sel    = 1'b0;
		dbgreg_in     = '0;
		dbg_ptr       = '0;
		btn_value     = $random(seed);
		btn           = btn_value;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;
		check_value(led, '0, "led after reset");
		check_value(fsel_d, 1'b0, "fsel_d after reset");
		check_value(fsel_c, 1'b0, "fsel_c after reset");
		check_value(programn, 1'b1, "programn after reset");
		check_value(bus_error_irq, 1'b0, "irq after reset");
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		$display("*** PASSED ***");
		$finish;
	end

	// run length scales with the table
	initial begin
		wait (table_ready);
		repeat (steps.size() * 60 + 200) @(posedge clk48m);
		$display("watchdog expired before the test table finished");
		abort_run();
	end

endmodule
